// File: vlog.f
hdl/cpuPkg.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/sequencer.sv
hdl/gbCpu.sv
testbench/gbCpu_chk.sv
testbench/cpuChecker.sv
testbench/tbGbCpu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbGbCpu
FILELIST  = vlog.f
LOG       = sim.log
SIMBIN    = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIMBIN)

$(SIMBIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(SIMBIN) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tbGbCpu.sv
module tbGbCpu;

  localparam int memSize   = 4096;
  localparam int progItems = 40;
  localparam int doneLimit = 50000;

  logic        clk;
  logic        reset;
  logic [15:0] memAddress;
  logic [7:0]  memDataR;
  logic [7:0]  memDataW;
  logic        rw;
  logic        halted;
  logic [7:0]  mem [0:memSize-1];
  logic [31:0] lfsr = 32'h3ee6;
  int          progLen;
  int          valueErrors;
  int          otherErrors;
  logic        checkDone;

  gbCpu UUT (
    .clk(clk),
    .reset(reset),
    .memAddress(memAddress),
    .memDataR(memDataR),
    .memDataW(memDataW),
    .rw(rw),
    .halted(halted)
  );

  cpuChecker #(.memSize(memSize)) check (
    .clk(clk),
    .reset(reset),
    .memAddress(memAddress),
    .memDataW(memDataW),
    .rw(rw),
    .halted(halted),
    .image(mem),
    .valueErrors(valueErrors),
    .otherErrors(otherErrors),
    .checkDone(checkDone)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [7:0] takeBits(input int count);
    logic [7:0] value;
    logic       fb;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr  = {lfsr[30:0], fb};
      value = {value[6:0], fb};
    end
    return value;
  endfunction

  function automatic logic [7:0] fillByte(input int addr);
    logic [11:0] a;
    a = addr[11:0];
    return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'ha5;
  endfunction

  function automatic logic [2:0] pickDest();
    return takeBits(1) ? 3'd7 : 3'(takeBits(2));   // B to E or A
  endfunction

  function automatic logic [2:0] pickSource();
    logic [2:0] s;
    s = 3'(takeBits(3));
    return (s == 3'd6) ? 3'd7 : s;
  endfunction

  task automatic emit(input logic [7:0] b);
    mem[progLen] = b;
    progLen++;
  endtask

  task automatic buildProgram();
    logic [7:0] kind, op;
    logic [2:0] dest;
    for (int a = 0; a < memSize; a++)
      mem[a] = fillByte(a);
    progLen = 0;
    emit(8'h21);   // LD HL into the data page
    emit(takeBits(8));
    emit(8'h0c | takeBits(2));
    emit(8'h01);
    emit(takeBits(8));
    emit(takeBits(8));
    emit(8'h11);
    emit(takeBits(8));
    emit(takeBits(8));
    for (int d = 0; d < 8; d++)
      if (d < 4 || d == 7)
      begin
        emit(8'(8'h06 | (d << 3)));
        emit(takeBits(8));
      end
    for (int i = 0; i < progItems; i++)
    begin
      kind = takeBits(3);
      op   = takeBits(3);
      case (kind)
        8'd0:
        begin
          emit(8'h06 | {pickDest(), 3'b000});
          emit(takeBits(8));
        end
        8'd1:    emit(8'h40 | {pickDest(), 3'b000} | pickSource());
        8'd2:    emit(8'h80 | {op[2:0], 3'b000} | pickSource());
        8'd3:    emit(8'h86 | {op[2:0], 3'b000});
        8'd4:
        begin
          emit(8'hc6 | {op[2:0], 3'b000});
          emit(takeBits(8));
        end
        8'd5:
        begin
          dest = pickDest();
          emit(8'h04 | {dest, 3'b000} | takeBits(1));   // INC or DEC
          emit(8'h70 | dest);
          emit(8'h30 | (takeBits(1) << 3));   // JR NC or JR C
          emit(8'h01);
        end
        8'd6:
        begin
          emit(8'h20 | (takeBits(2) << 3));
          emit(8'h01);   // Skips the one-byte store
          emit(8'h70 | pickSource());
        end
        default:
          if (takeBits(1))
          begin
            emit(8'h21);
            emit(takeBits(8));
            emit(8'h0c | takeBits(2));
          end
          else
            emit(8'h46 | {pickDest(), 3'b000});
      endcase
      if (kind >= 8'd2 && kind <= 8'd4)
        emit(8'h77);
      else if (kind != 8'd6)
        emit(8'h70 | pickSource());
    end
    emit(8'h2f);   // CPL, outside the subset
    emit(8'h77);
    emit(8'h76);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Synchronous memory, read data one cycle after the address
  initial
  begin
    int addr;
    memDataR = 8'd0;
    forever
    begin
      @(negedge clk);
      addr = int'(memAddress) % memSize;
      if (rw === 1'b1)
        mem[addr] = memDataW;
      @(posedge clk);
      #1 memDataR = mem[addr];
    end
  end

  initial
  begin
    int cycles;
    reset = 1'b1;
    buildProgram();
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    cycles = 0;
    while (checkDone !== 1'b1 && cycles < doneLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (checkDone !== 1'b1)
      $display("Checker did not finish within %0d cycles", doneLimit);
    $display("Errors: %0d value, %0d other, %0d assertion", valueErrors, otherErrors,
             UUT.chk.failures);
    if (checkDone === 1'b1 && valueErrors == 0 && otherErrors == 0 && UUT.chk.failures == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: testbench/cpuChecker.sv
module cpuChecker #(
  parameter int memSize = 4096
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] memAddress,
  input  logic [7:0]  memDataW,
  input  logic        rw,
  input  logic        halted,
  input  logic [7:0]  image [0:memSize-1],
  output int          valueErrors,
  output int          otherErrors,
  output logic        checkDone
);

  localparam int resetTimeout   = 100;
  localparam int writeTimeout   = 200;   // Cycles between writes or before halt
  localparam int postHaltCycles = 20;
  localparam int stepLimit      = 10000;

  logic [7:0]  model [0:memSize-1];
  logic [7:0]  r [0:7];                  // B C D E H L - A
  logic        fz, fn, fh, fc;
  logic [15:0] expAddr [$];
  logic [7:0]  expData [$];

  function automatic int hlAddr();
    return {r[4], r[5]} % memSize;
  endfunction

  function automatic logic [7:0] readSrc(input logic [2:0] src);
    return (src == 3'd6) ? model[hlAddr()] : r[src];
  endfunction

  function automatic void storeByte(input int addr, input logic [7:0] data);
    model[addr] = data;
    expAddr.push_back(addr[15:0]);
    expData.push_back(data);
  endfunction

  function automatic void aluRef(input logic [2:0] op, input logic [7:0] v);
    int a, b, cin, res, low;
    a   = r[7];
    b   = v;
    cin = (op == 3'd1 || op == 3'd3) ? int'(fc) : 0;
    res = 0;
    case (op)
      3'd0, 3'd1:
      begin
        res = a + b + cin;
        low = (a % 16) + (b % 16) + cin;
        fn  = 0;
        fh  = low > 15;
        fc  = res > 255;
      end
      3'd2, 3'd3, 3'd7:
      begin
        res = a - b - cin;
        low = (a % 16) - (b % 16) - cin;
        fn  = 1;
        fh  = low < 0;
        fc  = res < 0;
      end
      default:
      begin
        if (op == 3'd4)
          res = a & b;
        else if (op == 3'd5)
          res = a ^ b;
        else
          res = a | b;
        fn = 0;
        fh = op == 3'd4;
        fc = 0;
      end
    endcase
    res = res & 255;
    fz  = res == 0;
    if (op != 3'd7)
      r[7] = res[7:0];   // CP keeps A
  endfunction

  function automatic void stepRef(input logic [2:0] dst, input logic isDec);
    logic [7:0] v;
    v      = r[dst];
    r[dst] = isDec ? v - 8'd1 : v + 8'd1;
    fh     = isDec ? v[3:0] == 4'h0 : v[3:0] == 4'hf;
    fn     = isDec;
    fz     = r[dst] == 8'd0;
  endfunction

  // Runs the program image until the first opcode outside the subset
  function automatic void runReference();
    int         pc, steps;
    logic [7:0] op, b;
    logic [1:0] x;
    logic [2:0] y, z;
    logic       taken, running;
    for (int i = 0; i < 8; i++)
      r[i] = 8'd0;
    {fz, fn, fh, fc} = 4'b0;
    running = 1;
    pc      = 0;
    steps   = 0;
    while (running && steps < stepLimit)
    begin
      op = model[pc % memSize];
      x  = op[7:6];
      y  = op[5:3];
      z  = op[2:0];
      b  = model[(pc + 1) % memSize];
      steps++;
      if (x == 0 && z == 0 && y[2])
      begin
        case (y[1:0])
          2'd0:    taken = !fz;
          2'd1:    taken = fz;
          2'd2:    taken = !fc;
          default: taken = fc;
        endcase
        pc = pc + 2;
        if (taken)
          pc = (pc + $signed(b)) & 16'hffff;
      end
      else if (x == 0 && z == 1 && !y[0] && y[2:1] != 2'd3)
      begin
        r[{y[2:1], 1'b0}] = model[(pc + 2) % memSize];
        r[{y[2:1], 1'b1}] = b;
        pc = pc + 3;
      end
      else if (x == 0 && (z == 4 || z == 5) && y != 6)
      begin
        stepRef(y, z[0]);
        pc = pc + 1;
      end
      else if (x == 0 && z == 6 && y != 6)
      begin
        r[y] = b;
        pc = pc + 2;
      end
      else if (x == 1 && !(y == 6 && z == 6))
      begin
        if (y == 6)
          storeByte(hlAddr(), readSrc(z));
        else
          r[y] = readSrc(z);
        pc = pc + 1;
      end
      else if (x == 2)
      begin
        aluRef(y, readSrc(z));
        pc = pc + 1;
      end
      else if (x == 3 && z == 6)
      begin
        aluRef(y, b);
        pc = pc + 2;
      end
      else
        running = 0;   // HALT or trap opcode
    end
    if (running)
    begin
      $display("Reference model never reached a trap opcode");
      otherErrors++;
    end
  endfunction

  function automatic void compareWrite(input int idx);
    if (idx >= expAddr.size())
    begin
      $display("%0t: unexpected write of %h to address %h", $time, memDataW, memAddress);
      otherErrors++;
    end
    else
    begin
      if (memAddress !== expAddr[idx])
      begin
        $display("** Error at %0t: memAddress is %h, expected %h", $time, memAddress,
                 expAddr[idx]);
        valueErrors++;
      end
      if (memDataW !== expData[idx])
      begin
        $display("** Error at %0t: memDataW is %h, expected %h", $time, memDataW,
                 expData[idx]);
        valueErrors++;
      end
    end
  endfunction

  initial
  begin
    int waitCycles;
    int idx;
    int idle;
    valueErrors = 0;
    otherErrors = 0;
    checkDone   = 1'b0;
    waitCycles  = 0;
    while (reset !== 1'b0 && waitCycles < resetTimeout)
    begin
      @(negedge clk);
      waitCycles++;
    end
    if (reset !== 1'b0)
    begin
      $display("Reset was never released");
      otherErrors++;
    end
    else
    begin
      for (int a = 0; a < memSize; a++)
        model[a] = image[a];
      runReference();
      idx  = 0;
      idle = 0;
      while (halted !== 1'b1 && idle < writeTimeout)
      begin
        @(negedge clk);
        if (rw === 1'b1)
        begin
          compareWrite(idx);
          idx++;
          idle = 0;
        end
        else
          idle++;
      end
      if (halted !== 1'b1)
      begin
        $display("%0t: halted did not rise within %0d cycles", $time, writeTimeout);
        otherErrors++;
      end
      if (idx < expAddr.size())
      begin
        $display("%0t: %0d expected writes never appeared", $time, expAddr.size() - idx);
        otherErrors++;
      end
      idle = 0;
      while (idle < postHaltCycles)
      begin
        @(negedge clk);
        if (rw === 1'b1)
        begin
          $display("%0t: write to %h after halt", $time, memAddress);
          otherErrors++;
        end
        idle++;
      end
    end
    checkDone = 1'b1;
  end

endmodule

// File: testbench/gbCpu_chk.sv
module gbCpuChk (
  input logic clk,
  input logic reset,
  input logic rw,
  input logic halted
);

  int failures = 0;

  // No bus write once the core sits in the trap state
  noWriteWhenHalted: assert property (@(posedge clk) disable iff (reset) halted |-> !rw)
  else
  begin
    failures++;
    $error("rw high while halted is high");
  end

  haltedHeldUntilReset: assert property (@(posedge clk) $fell(halted) |-> $past(reset))
  else
  begin
    failures++;
    $error("halted fell without reset");
  end

  quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !rw)
  else
  begin
    failures++;
    $error("rw high in the first cycle after reset");
  end

endmodule

bind gbCpu gbCpuChk chk (.clk(clk), .reset(reset), .rw(rw), .halted(halted));

// File: hdl/gbCpu.sv
module gbCpu (
  input  logic                         clk,
  input  logic                         reset,
  output logic [cpuPkg::addrWidth-1:0] memAddress,
  input  logic [cpuPkg::dataWidth-1:0] memDataR,
  output logic [cpuPkg::dataWidth-1:0] memDataW,
  output logic                         rw,
  output logic                         halted
);

  // Register file side
  logic [2:0]                   regNum;
  logic [cpuPkg::dataWidth-1:0] dataIn;
  logic [cpuPkg::addrWidth-1:0] dataIn16;
  logic                         writeEnable8;
  logic                         writeEnable16;
  logic [cpuPkg::dataWidth-1:0] dataOut;
  logic [cpuPkg::addrWidth-1:0] dataOut16;

  // ALU side
  cpuPkg::aluOpT                aluOp;
  logic [cpuPkg::dataWidth-1:0] operandX;
  logic [cpuPkg::dataWidth-1:0] operandY;
  logic                         execute;
  logic                         incDec;
  logic                         dec;
  logic                         writeA;
  logic                         loadA;
  logic [cpuPkg::dataWidth-1:0] regA;
  logic [3:0]                   flags;
  logic [cpuPkg::dataWidth-1:0] result;

  sequencer sequencer (
    .*
  );

  registerFile registerFile (
    .*
  );

  alu alu (
    .*
  );

endmodule

// File: hdl/sequencer.sv
module sequencer (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [cpuPkg::dataWidth-1:0] memDataR,
  output logic [cpuPkg::addrWidth-1:0] memAddress,
  output logic [cpuPkg::dataWidth-1:0] memDataW,
  output logic                         rw,
  output logic                         halted,
  output logic [2:0]                   regNum,
  output logic [cpuPkg::dataWidth-1:0] dataIn,
  output logic [cpuPkg::addrWidth-1:0] dataIn16,
  output logic                         writeEnable8,
  output logic                         writeEnable16,
  input  logic [cpuPkg::dataWidth-1:0] dataOut,
  input  logic [cpuPkg::addrWidth-1:0] dataOut16,
  output cpuPkg::aluOpT                aluOp,
  output logic [cpuPkg::dataWidth-1:0] operandX,
  output logic [cpuPkg::dataWidth-1:0] operandY,
  output logic                         execute,
  output logic                         incDec,
  output logic                         dec,
  output logic                         writeA,
  output logic                         loadA,
  input  logic [cpuPkg::dataWidth-1:0] regA,
  input  logic [3:0]                   flags,
  input  logic [cpuPkg::dataWidth-1:0] result
);

  cpuPkg::stateT                state;
  cpuPkg::opcodeT               opcode;
  logic [cpuPkg::addrWidth-1:0] pc;
  logic [cpuPkg::addrWidth-1:0] pcNext;
  logic                         isJr;
  logic                         isLd16;
  logic                         isIncDec;
  logic                         isLdImm;
  logic                         isLdReg;
  logic                         isLdMem;
  logic                         isStMem;
  logic                         isAluReg;
  logic                         isAluMem;
  logic                         isAluImm;
  logic                         usesHl;
  logic                         jrTaken;
  logic [2:0]                   selReg;
  logic [cpuPkg::dataWidth-1:0] operandByte;

  assign pcNext = pc + 16'd1;

  assign isJr     = opcode.xyz.x == 2'd0 && opcode.xyz.z == 3'd0 && opcode.xyz.y[2];
  assign isLd16   = opcode.xpqz.x == 2'd0 && opcode.xpqz.z == 3'd1 && !opcode.xpqz.q &&
                    opcode.xpqz.p != 2'd3;   // No SP
  assign isIncDec = opcode.xyz.x == 2'd0 && opcode.xyz.z[2:1] == 2'b10 &&
                    opcode.xyz.y != cpuPkg::regMem;
  assign isLdImm  = opcode.xyz.x == 2'd0 && opcode.xyz.z == 3'd6 &&
                    opcode.xyz.y != cpuPkg::regMem;
  assign isLdReg  = opcode.xyz.x == 2'd1 && opcode.xyz.y != cpuPkg::regMem &&
                    opcode.xyz.z != cpuPkg::regMem;
  assign isLdMem  = opcode.xyz.x == 2'd1 && opcode.xyz.z == cpuPkg::regMem &&
                    opcode.xyz.y != cpuPkg::regMem;
  assign isStMem  = opcode.xyz.x == 2'd1 && opcode.xyz.y == cpuPkg::regMem &&
                    opcode.xyz.z != cpuPkg::regMem;
  assign isAluReg = opcode.xyz.x == 2'd2 && opcode.xyz.z != cpuPkg::regMem;
  assign isAluMem = opcode.xyz.x == 2'd2 && opcode.xyz.z == cpuPkg::regMem;
  assign isAluImm = opcode.xyz.x == 2'd3 && opcode.xyz.z == 3'd6;
  assign usesHl   = isLdMem || isStMem || isAluMem;

  assign selReg      = isIncDec ? opcode.xyz.y : opcode.xyz.z;
  assign operandByte = (selReg == cpuPkg::regAcc) ? regA : dataOut;

  always_comb
  begin
    case (opcode.xyz.y[1:0])
      2'd0:    jrTaken = !flags[cpuPkg::flagZero];    // NZ
      2'd1:    jrTaken = flags[cpuPkg::flagZero];     // Z
      2'd2:    jrTaken = !flags[cpuPkg::flagCarry];   // NC
      default: jrTaken = flags[cpuPkg::flagCarry];    // C
    endcase
  end

  task automatic writeDest(input logic [2:0] dest, input logic [7:0] value);
    if (dest == cpuPkg::regAcc)
    begin
      operandX <= value;
      loadA    <= 1'b1;
    end
    else
    begin
      regNum       <= dest;
      dataIn       <= value;
      writeEnable8 <= 1'b1;
    end
  endtask

  task automatic startAlu(input logic [7:0] value);
    aluOp    <= cpuPkg::aluOpT'(opcode.xyz.y);
    operandX <= regA;
    operandY <= value;
    execute  <= 1'b1;
  endtask

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state         <= cpuPkg::fetch0;
      pc            <= '0;
      memAddress    <= '0;
      rw            <= 1'b0;
      halted        <= 1'b0;
      regNum        <= cpuPkg::regB;
      writeEnable8  <= 1'b0;
      writeEnable16 <= 1'b0;
      aluOp         <= cpuPkg::aluAdd;
      execute       <= 1'b0;
      incDec        <= 1'b0;
      dec           <= 1'b0;
      writeA        <= 1'b0;
      loadA         <= 1'b0;
    end
    else
    begin
      rw            <= 1'b0;   // Strobes last one cycle
      writeEnable8  <= 1'b0;
      writeEnable16 <= 1'b0;
      execute       <= 1'b0;
      incDec        <= 1'b0;
      writeA        <= 1'b0;
      loadA         <= 1'b0;
      case (state)
        cpuPkg::fetch0:
        begin
          memAddress <= pc;
          state      <= cpuPkg::fetch1;
        end
        cpuPkg::fetch1:
        begin
          pc         <= pcNext;
          memAddress <= pcNext;   // Pre-fetch operand
          state      <= cpuPkg::decode;
        end
        cpuPkg::decode:
        begin
          opcode <= memDataR;
          state  <= cpuPkg::execute0;
        end
        cpuPkg::execute0:
        begin
          if (isJr)
          begin
            pc <= pcNext;
            if (jrTaken)
              state <= cpuPkg::execute1;
            else
              state <= cpuPkg::fetch0;
          end
          else if (isLd16)
          begin
            dataIn16[7:0] <= memDataR;   // Low byte first
            pc            <= pcNext;
            memAddress    <= pcNext;
            state         <= cpuPkg::execute1;
          end
          else if (isLdImm)
          begin
            writeDest(opcode.xyz.y, memDataR);
            pc    <= pcNext;
            state <= cpuPkg::fetch0;
          end
          else if (isAluImm)
          begin
            startAlu(memDataR);
            pc    <= pcNext;
            state <= cpuPkg::fetch0;
          end
          else if (isIncDec || isLdReg || isAluReg || usesHl)
          begin
            regNum <= usesHl ? cpuPkg::regH : selReg;
            state  <= cpuPkg::execute1;
          end
          else
          begin
            halted <= 1'b1;   // HALT or unsupported
            state  <= cpuPkg::trap;
          end
        end
        cpuPkg::execute1:
        begin
          if (isJr)
          begin
            pc    <= pc + {{8{memDataR[7]}}, memDataR};
            state <= cpuPkg::fetch0;
          end
          else
            state <= cpuPkg::execute2;   // Register read in flight
        end
        cpuPkg::execute2:
        begin
          if (isLd16)
          begin
            dataIn16[15:8] <= memDataR;
            regNum         <= {opcode.xpqz.p, 1'b0};
            writeEnable16  <= 1'b1;
            pc             <= pcNext;
            state          <= cpuPkg::fetch0;
          end
          else if (isLdReg)
          begin
            writeDest(opcode.xyz.y, operandByte);
            state <= cpuPkg::fetch0;
          end
          else if (isAluReg)
          begin
            startAlu(operandByte);
            state <= cpuPkg::fetch0;
          end
          else if (isIncDec)
          begin
            operandX <= operandByte;
            incDec   <= 1'b1;
            dec      <= opcode.xyz.z[0];
            writeA   <= opcode.xyz.y == cpuPkg::regAcc;
            if (opcode.xyz.y == cpuPkg::regAcc)
              state <= cpuPkg::fetch0;
            else
              state <= cpuPkg::execute3;
          end
          else
          begin
            memAddress <= dataOut16;   // HL
            regNum     <= selReg;
            state      <= cpuPkg::execute3;
          end
        end
        cpuPkg::execute3:
          state <= cpuPkg::execute4;   // ALU result or bus read in flight
        cpuPkg::execute4:
        begin
          if (isIncDec)
          begin
            dataIn       <= result;
            writeEnable8 <= 1'b1;
          end
          else if (isStMem)
          begin
            memDataW <= operandByte;
            rw       <= 1'b1;
          end
          else if (isLdMem)
            writeDest(opcode.xyz.y, memDataR);
          else
            startAlu(memDataR);
          state <= cpuPkg::fetch0;
        end
        default:
          state <= cpuPkg::trap;   // Only reset leaves
      endcase
    end
  end

endmodule

// File: hdl/alu.sv
module alu (
  input  logic                         clk,
  input  logic                         reset,
  input  cpuPkg::aluOpT                aluOp,
  input  logic [cpuPkg::dataWidth-1:0] operandX,
  input  logic [cpuPkg::dataWidth-1:0] operandY,
  input  logic                         execute,
  input  logic                         incDec,
  input  logic                         dec,
  input  logic                         writeA,
  input  logic                         loadA,
  output logic [cpuPkg::dataWidth-1:0] regA,
  output logic [3:0]                   flags,
  output logic [cpuPkg::dataWidth-1:0] result
);

  logic       carryIn;
  logic [4:0] lowSum;
  logic [8:0] fullSum;
  logic [3:0] opFlags;
  logic [7:0] stepOut;
  logic [3:0] stepFlags;

  assign carryIn = (aluOp == cpuPkg::aluAdc || aluOp == cpuPkg::aluSbc) &&
                   flags[cpuPkg::flagCarry];

  always_comb
  begin
    lowSum  = '0;
    fullSum = '0;
    opFlags = '0;
    case (aluOp)
      cpuPkg::aluAdd, cpuPkg::aluAdc:
      begin
        lowSum  = {1'b0, operandX[3:0]} + {1'b0, operandY[3:0]} + {4'b0, carryIn};
        fullSum = {1'b0, operandX} + {1'b0, operandY} + {8'b0, carryIn};
        opFlags[cpuPkg::flagHalf]  = lowSum[4];
        opFlags[cpuPkg::flagCarry] = fullSum[8];
      end
      cpuPkg::aluSub, cpuPkg::aluSbc, cpuPkg::aluCp:
      begin
        lowSum  = {1'b0, operandX[3:0]} - {1'b0, operandY[3:0]} - {4'b0, carryIn};
        fullSum = {1'b0, operandX} - {1'b0, operandY} - {8'b0, carryIn};
        opFlags[cpuPkg::flagSub]   = 1'b1;
        opFlags[cpuPkg::flagHalf]  = lowSum[4];    // Borrow wraps into bit 4
        opFlags[cpuPkg::flagCarry] = fullSum[8];
      end
      cpuPkg::aluAnd:
      begin
        fullSum = {1'b0, operandX & operandY};
        opFlags[cpuPkg::flagHalf] = 1'b1;
      end
      cpuPkg::aluXor:
        fullSum = {1'b0, operandX ^ operandY};
      cpuPkg::aluOr:
        fullSum = {1'b0, operandX | operandY};
    endcase
    opFlags[cpuPkg::flagZero] = fullSum[7:0] == 8'd0;
  end

  always_comb
  begin
    stepOut = dec ? operandX - 8'd1 : operandX + 8'd1;
    stepFlags[cpuPkg::flagZero]  = stepOut == 8'd0;
    stepFlags[cpuPkg::flagSub]   = dec;
    stepFlags[cpuPkg::flagHalf]  = dec ? operandX[3:0] == 4'h0 : operandX[3:0] == 4'hf;
    stepFlags[cpuPkg::flagCarry] = flags[cpuPkg::flagCarry];   // INC/DEC keep C
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regA   <= '0;
      flags  <= '0;
      result <= '0;
    end
    else if (execute)
    begin
      result <= fullSum[7:0];
      flags  <= opFlags;
      if (aluOp != cpuPkg::aluCp)
        regA <= fullSum[7:0];
    end
    else if (incDec)
    begin
      result <= stepOut;
      flags  <= stepFlags;
      if (writeA)
        regA <= stepOut;
    end
    else if (loadA)
      regA <= operandX;
  end

endmodule

// File: hdl/registerFile.sv
module registerFile (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [2:0]                   regNum,
  input  logic [cpuPkg::dataWidth-1:0] dataIn,
  input  logic                         writeEnable8,
  input  logic [cpuPkg::addrWidth-1:0] dataIn16,
  input  logic                         writeEnable16,
  output logic [cpuPkg::dataWidth-1:0] dataOut,
  output logic [cpuPkg::addrWidth-1:0] dataOut16
);

  logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regB:cpuPkg::regL];
  logic [2:0]                   pairHigh;
  logic [2:0]                   pairLow;

  always_comb
  begin
    case (regNum)
      cpuPkg::regB, cpuPkg::regC:
      begin
        pairHigh = cpuPkg::regB;
        pairLow  = cpuPkg::regC;
      end
      cpuPkg::regD, cpuPkg::regE:
      begin
        pairHigh = cpuPkg::regD;
        pairLow  = cpuPkg::regE;
      end
      default:
      begin
        pairHigh = cpuPkg::regH;
        pairLow  = cpuPkg::regL;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = cpuPkg::regB; i <= cpuPkg::regL; i++)
        regs[i] <= '0;
    end
    else if (writeEnable16)
    begin
      regs[pairHigh] <= dataIn16[15:8];
      regs[pairLow]  <= dataIn16[7:0];
    end
    else if (writeEnable8 && regNum <= cpuPkg::regL)
      regs[regNum] <= dataIn;
  end

  always_ff @(posedge clk)
  begin
    dataOut   <= (regNum <= cpuPkg::regL) ? regs[regNum] : '0;   // A and [HL] live elsewhere
    dataOut16 <= {regs[pairHigh], regs[pairLow]};
  end

endmodule

// File: hdl/cpuPkg.sv
package cpuPkg;

  localparam int dataWidth = 8;
  localparam int addrWidth = 16;

  // Sequencer states
  typedef enum logic [3:0] {
    fetch0,
    fetch1,
    decode,
    execute0,
    execute1,
    execute2,
    execute3,
    execute4,
    trap
  } stateT;

  // Register numbers as encoded in opcode y and z
  localparam logic [2:0] regB   = 3'd0;
  localparam logic [2:0] regC   = 3'd1;
  localparam logic [2:0] regD   = 3'd2;
  localparam logic [2:0] regE   = 3'd3;
  localparam logic [2:0] regH   = 3'd4;
  localparam logic [2:0] regL   = 3'd5;
  localparam logic [2:0] regMem = 3'd6;   // [HL]
  localparam logic [2:0] regAcc = 3'd7;   // A

  // Same order as opcode bits y of the ALU group
  typedef enum logic [2:0] {
    aluAdd,
    aluAdc,
    aluSub,
    aluSbc,
    aluAnd,
    aluXor,
    aluOr,
    aluCp
  } aluOpT;

  localparam int flagZero  = 3;
  localparam int flagSub   = 2;
  localparam int flagHalf  = 1;
  localparam int flagCarry = 0;

  typedef union packed {
    struct packed {
      logic [1:0] x;
      logic [2:0] y;
      logic [2:0] z;
    } xyz;
    struct packed {
      logic [1:0] x;
      logic [1:0] p;      // Register pair
      logic       q;
      logic [2:0] z;
    } xpqz;
  } opcodeT;

endpackage
